// ==== include/rob_defs.svh ====
`ifndef ROB_DEFS_SVH
`define ROB_DEFS_SVH

// register data width.
`define DATA_W 32

// 32 architectural registers where r0 reads zero.
`define REG_ADDR_W 5

// reorder buffer tag width and a depth that equals 2**ROB_TAG_W.
`define ROB_TAG_W 3
`define ROB_DEPTH 8

// downstream retire credits granted after reset.
`define RETIRE_CREDITS 4

`endif

// ==== sim.f ====
+incdir+include
src/rob_pkg.sv
src/rename_stage.sv
src/reg_file.sv
src/reorder_buffer.sv
src/commit_stage.sv
src/rename_commit_top.sv
tb/rename_commit_tb.sv

// ==== src/commit_stage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rob_defs.svh"

module commit_stage (
  input  wire                clk,
  input  wire                rst,
  input  wire                flush,
  input  wire                head_valid,
  input  wire rob_pkg::commit_t head,
  input  wire                retire_credit,
  output logic               commit_en,
  output logic               retire_valid,
  output rob_pkg::commit_t   retire,
  output logic               dispatch_credit
);

  localparam int CREDIT_W = $clog2(`RETIRE_CREDITS + 1);

  logic [CREDIT_W-1:0] credits;

  // head waits here when downstream has no room.
  assign commit_en = head_valid && (credits != '0) && !flush;

  always_ff @(posedge clk) begin
    if (!rst) begin
      credits         <= CREDIT_W'(`RETIRE_CREDITS);
      retire_valid    <= 1'b0;
      dispatch_credit <= 1'b0;
    end else begin
      case ({commit_en, retire_credit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
      retire_valid    <= commit_en;
      dispatch_credit <= commit_en; // one freed entry per commit.
    end
  end

  always_ff @(posedge clk) begin
    if (commit_en) begin
      retire <= head;
    end
  end

  // downstream must not return more credits than it was granted.
  a_credit_bound : assert property (@(posedge clk) disable iff (!rst)
    credits <= `RETIRE_CREDITS)
    else $error("commit_stage: retire credits above %0d", `RETIRE_CREDITS);

endmodule

`default_nettype wire

// ==== src/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rob_defs.svh"

module reg_file (
  input  wire                  clk,
  input  wire                  rst,
  input  wire                  flush,
  input  wire rob_pkg::reg_addr_t rd_addr1,
  input  wire rob_pkg::reg_addr_t rd_addr2,
  output rob_pkg::operand_t    op1,
  output rob_pkg::operand_t    op2,
  input  wire                  ref_we,
  input  wire rob_pkg::reg_addr_t ref_addr,
  input  wire rob_pkg::rob_tag_t  ref_tag,
  input  wire                  commit_en,
  input  wire rob_pkg::commit_t   head
);

  localparam int NUM_REGS = 1 << `REG_ADDR_W;

  rob_pkg::data_t            values   [0:NUM_REGS-1];
  rob_pkg::rob_tag_t         ref_tags [0:NUM_REGS-1];
  logic [NUM_REGS-1:0]       ref_valid;
  logic                      commit_fire;
  logic                      commit_hit;

  assign commit_fire = commit_en && !flush;

  // reference still names the committing tag.
  assign commit_hit = commit_fire && ref_valid[head.dest] && (ref_tags[head.dest] == head.tag);

  always_ff @(posedge clk) begin
    if (!rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        values[i] <= '0;
      end
      ref_valid <= '0;
    end else begin
      if (commit_fire && (head.dest != {`REG_ADDR_W{1'b0}})) begin
        values[head.dest] <= head.data;
      end
      if (flush) begin
        ref_valid <= '0;
      end else begin
        if (commit_hit) begin
          ref_valid[head.dest] <= 1'b0;
        end
        // a tag write to the same register overrides the clear above.
        if (ref_we) begin
          ref_valid[ref_addr] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ref_we) begin
      ref_tags[ref_addr] <= ref_tag;
    end
  end

  function automatic rob_pkg::operand_t read_port(input rob_pkg::reg_addr_t addr);
    rob_pkg::operand_t rd;
    rd = '0;
    if (addr == {`REG_ADDR_W{1'b0}}) begin
      rd = '0;
    end else if (ref_valid[addr] && commit_fire && (ref_tags[addr] == head.tag)) begin
      rd.value = head.data; // committing tag bypass.
    end else if (ref_valid[addr]) begin
      rd.is_ref = 1'b1;
      rd.value[`ROB_TAG_W-1:0] = ref_tags[addr];
    end else begin
      rd.value = values[addr];
    end
    return rd;
  endfunction

  always_comb begin
    op1 = read_port(rd_addr1);
    op2 = read_port(rd_addr2);
  end

endmodule

`default_nettype wire

// ==== src/rename_commit_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rob_defs.svh"

module rename_commit_top (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   dispatch_valid,
  input  wire rob_pkg::dispatch_t  dispatch,
  input  wire                   wb_valid,
  input  wire rob_pkg::writeback_t wb,
  input  wire                   flush,
  input  wire                   retire_credit,
  output logic                  dispatch_credit,
  output logic                  issue_valid,
  output rob_pkg::issue_t       issue,
  output logic                  retire_valid,
  output rob_pkg::commit_t      retire
);

  logic               alloc_valid;
  rob_pkg::rob_tag_t  alloc_tag;
  rob_pkg::reg_addr_t rd_addr1;
  rob_pkg::reg_addr_t rd_addr2;
  rob_pkg::operand_t  op1;
  rob_pkg::operand_t  op2;
  logic               ref_we;
  rob_pkg::reg_addr_t ref_addr;
  rob_pkg::rob_tag_t  ref_tag;
  logic               commit_en;
  logic               head_valid;
  rob_pkg::commit_t   head;

  rename_stage u_rename (
    .clk            (clk),
    .rst            (rst),
    .dispatch_valid (dispatch_valid),
    .dispatch       (dispatch),
    .alloc_tag      (alloc_tag),
    .op1            (op1),
    .op2            (op2),
    .alloc_valid    (alloc_valid),
    .rd_addr1       (rd_addr1),
    .rd_addr2       (rd_addr2),
    .ref_we         (ref_we),
    .ref_addr       (ref_addr),
    .ref_tag        (ref_tag),
    .issue_valid    (issue_valid),
    .issue          (issue)
  );

  reg_file u_reg_file (
    .clk       (clk),
    .rst       (rst),
    .flush     (flush),
    .rd_addr1  (rd_addr1),
    .rd_addr2  (rd_addr2),
    .op1       (op1),
    .op2       (op2),
    .ref_we    (ref_we),
    .ref_addr  (ref_addr),
    .ref_tag   (ref_tag),
    .commit_en (commit_en),
    .head      (head)
  );

  reorder_buffer u_rob (
    .clk         (clk),
    .rst         (rst),
    .flush       (flush),
    .alloc_valid (alloc_valid),
    .dispatch    (dispatch),
    .alloc_tag   (alloc_tag),
    .wb_valid    (wb_valid),
    .wb          (wb),
    .commit_en   (commit_en),
    .head_valid  (head_valid),
    .head        (head)
  );

  commit_stage u_commit (
    .clk             (clk),
    .rst             (rst),
    .flush           (flush),
    .head_valid      (head_valid),
    .head            (head),
    .retire_credit   (retire_credit),
    .commit_en       (commit_en),
    .retire_valid    (retire_valid),
    .retire          (retire),
    .dispatch_credit (dispatch_credit)
  );

endmodule

`default_nettype wire

// ==== src/rename_stage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rob_defs.svh"

module rename_stage (
  input  wire                 clk,
  input  wire                 rst,
  input  wire                 dispatch_valid,
  input  wire rob_pkg::dispatch_t dispatch,
  input  wire rob_pkg::rob_tag_t  alloc_tag,
  input  wire rob_pkg::operand_t  op1,
  input  wire rob_pkg::operand_t  op2,
  output logic                alloc_valid,
  output rob_pkg::reg_addr_t  rd_addr1,
  output rob_pkg::reg_addr_t  rd_addr2,
  output logic                ref_we,
  output rob_pkg::reg_addr_t  ref_addr,
  output rob_pkg::rob_tag_t   ref_tag,
  output logic                issue_valid,
  output rob_pkg::issue_t     issue
);

  logic dest_is_zero;

  assign dest_is_zero = (dispatch.dest == {`REG_ADDR_W{1'b0}});

  // every dispatch takes the tail entry.
  assign alloc_valid = dispatch_valid;

  assign rd_addr1 = dispatch.src1;
  assign rd_addr2 = dispatch.src2;

  assign ref_we   = dispatch_valid && !dest_is_zero; // r0 never takes a reference.
  assign ref_addr = dispatch.dest;
  assign ref_tag  = alloc_tag;

  always_ff @(posedge clk) begin
    if (!rst) begin
      issue_valid <= 1'b0;
    end else begin
      issue_valid <= dispatch_valid;
    end
  end

  // operands are sampled before the new reference lands.
  always_ff @(posedge clk) begin
    if (dispatch_valid) begin
      issue.tag  <= alloc_tag;
      issue.dest <= dispatch.dest;
      issue.op1  <= op1;
      issue.op2  <= op2;
    end
  end

endmodule

`default_nettype wire

// ==== src/reorder_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rob_defs.svh"

module reorder_buffer (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   flush,
  input  wire                   alloc_valid,
  input  wire rob_pkg::dispatch_t  dispatch,
  output rob_pkg::rob_tag_t     alloc_tag,
  input  wire                   wb_valid,
  input  wire rob_pkg::writeback_t wb,
  input  wire                   commit_en,
  output logic                  head_valid,
  output rob_pkg::commit_t      head
);

  rob_pkg::reg_addr_t       entry_dest [0:`ROB_DEPTH-1];
  rob_pkg::data_t           entry_data [0:`ROB_DEPTH-1];
  logic [`ROB_DEPTH-1:0]    entry_valid;
  logic [`ROB_DEPTH-1:0]    entry_done;
  rob_pkg::rob_tag_t        head_ptr;
  rob_pkg::rob_tag_t        tail_ptr;
  logic [`ROB_TAG_W:0]      count;
  logic                     commit_fire;

  assign commit_fire = commit_en && head_valid && !flush;

  assign alloc_tag  = tail_ptr;
  assign head_valid = entry_valid[head_ptr] && entry_done[head_ptr];

  assign head.tag  = head_ptr;
  assign head.dest = entry_dest[head_ptr];
  assign head.data = entry_data[head_ptr];

  always_ff @(posedge clk) begin
    if (!rst) begin
      entry_valid <= '0;
      entry_done  <= '0;
      head_ptr    <= '0;
      tail_ptr    <= '0;
      count       <= '0;
    end else if (flush) begin
      // drop everything in flight.
      entry_valid <= '0;
      entry_done  <= '0;
      head_ptr    <= '0;
      tail_ptr    <= '0;
      count       <= '0;
    end else begin
      if (alloc_valid) begin
        entry_valid[tail_ptr] <= 1'b1;
        entry_done[tail_ptr]  <= 1'b0;
        tail_ptr              <= tail_ptr + 1'b1; // wraps at depth.
      end
      if (wb_valid) begin
        entry_done[wb.tag] <= 1'b1;
      end
      if (commit_fire) begin
        entry_valid[head_ptr] <= 1'b0;
        head_ptr              <= head_ptr + 1'b1;
      end
      count <= count + {{`ROB_TAG_W{1'b0}}, alloc_valid}
                     - {{`ROB_TAG_W{1'b0}}, commit_fire};
    end
  end

  always_ff @(posedge clk) begin
    if (alloc_valid) begin
      entry_dest[tail_ptr] <= dispatch.dest;
    end
    if (wb_valid) begin
      entry_data[wb.tag] <= wb.data;
    end
  end

  // upstream credits must keep dispatch within the buffer.
  a_no_alloc_full : assert property (@(posedge clk) disable iff (!rst)
    alloc_valid |-> (count < `ROB_DEPTH))
    else $error("reorder_buffer: allocation while full");

  // execution may only write back tags that are still in flight.
  a_wb_in_flight : assert property (@(posedge clk) disable iff (!rst)
    wb_valid |-> entry_valid[wb.tag])
    else $error("reorder_buffer: writeback to tag %0d not in flight", wb.tag);

endmodule

`default_nettype wire

// ==== src/rob_pkg.sv ====
`default_nettype none
`include "rob_defs.svh"

package rob_pkg;

  typedef logic [`DATA_W-1:0]     data_t;
  typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [`ROB_TAG_W-1:0]  rob_tag_t;

  typedef struct packed {
    reg_addr_t dest;
    reg_addr_t src1;
    reg_addr_t src2;
  } dispatch_t;

  typedef struct packed {
    logic  is_ref; // value holds the zero-extended tag when set.
    data_t value;
  } operand_t;

  typedef struct packed {
    rob_tag_t  tag;
    reg_addr_t dest;
    operand_t  op1;
    operand_t  op2;
  } issue_t;

  typedef struct packed {
    rob_tag_t tag;
    data_t    data;
  } writeback_t;

  typedef struct packed {
    rob_tag_t  tag;
    reg_addr_t dest;
    data_t     data;
  } commit_t;

endpackage

`default_nettype wire

// ==== tb/rename_commit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rob_defs.svh"

module rename_commit_tb;

  localparam int NUM_CYCLES   = 2000;
  localparam int IDLE_CYCLES  = 4;
  localparam int DRAIN_CYCLES = 80;
  localparam int NUM_REGS     = 1 << `REG_ADDR_W;
  localparam int TIMEOUT_NS   = (NUM_CYCLES + 5 + 200) * 8;

  typedef struct packed {
    rob_pkg::rob_tag_t  tag;
    rob_pkg::reg_addr_t dest;
    rob_pkg::data_t     data;
    logic               done;
  } entry_t;

  logic                clk;
  logic                rst;
  logic                dispatch_valid;
  rob_pkg::dispatch_t  dispatch;
  logic                wb_valid;
  rob_pkg::writeback_t wb;
  logic                flush;
  logic                retire_credit;
  logic                dispatch_credit;
  logic                issue_valid;
  rob_pkg::issue_t     issue;
  logic                retire_valid;
  rob_pkg::commit_t    retire;

  rob_pkg::data_t      arch_val [0:NUM_REGS-1];
  rob_pkg::rob_tag_t   arch_tag [0:NUM_REGS-1];
  logic [NUM_REGS-1:0] arch_ref;
  entry_t              inflight [$];
  rob_pkg::rob_tag_t   next_tag;
  int                  ret_credits;
  int                  disp_credits;
  int                  pending_ret;
  int                  retired_total;
  int                  credit_pulses;
  int                  granted_total;
  int                  errors;
  logic                exp_issue_valid;
  logic                exp_retire_valid;
  rob_pkg::issue_t     exp_issue;
  rob_pkg::commit_t    exp_retire;
  logic [31:0]         lcg_state;

  rename_commit_top uut (
    .clk             (clk),
    .rst             (rst),
    .dispatch_valid  (dispatch_valid),
    .dispatch        (dispatch),
    .wb_valid        (wb_valid),
    .wb              (wb),
    .flush           (flush),
    .retire_credit   (retire_credit),
    .dispatch_credit (dispatch_credit),
    .issue_valid     (issue_valid),
    .issue           (issue),
    .retire_valid    (retire_valid),
    .retire          (retire)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state ^ (lcg_state >> 16); // low bits of a plain lcg cycle too fast.
  endfunction

  task automatic check_value(input logic [127:0] actual, input logic [127:0] expected,
                             input string what);
    if (actual !== expected) begin
      errors++;
      $display("error at %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
    end
  endtask

  // operand as the rename stage should see it before the coming edge.
  function automatic rob_pkg::operand_t predict_read(input rob_pkg::reg_addr_t addr,
                                                     input logic commit_now,
                                                     input rob_pkg::commit_t hd);
    rob_pkg::operand_t op;
    op = '0;
    if (addr == '0) begin
      op = '0;
    end else if (arch_ref[addr] && commit_now && (arch_tag[addr] == hd.tag)) begin
      op.value = hd.data;
    end else if (arch_ref[addr]) begin
      op.is_ref = 1'b1;
      op.value  = {{(`DATA_W-`ROB_TAG_W){1'b0}}, arch_tag[addr]};
    end else begin
      op.value = arch_val[addr];
    end
    return op;
  endfunction

  task automatic observe_outputs();
    check_value(issue_valid, exp_issue_valid, "issue_valid");
    if (exp_issue_valid && issue_valid) begin
      check_value(issue, exp_issue, "issue");
    end
    check_value(retire_valid, exp_retire_valid, "retire_valid");
    if (exp_retire_valid && retire_valid) begin
      check_value(retire, exp_retire, "retire");
    end
    check_value(dispatch_credit, exp_retire_valid, "dispatch_credit");
    if (retire_valid) begin
      retired_total++;
      pending_ret++;
    end
    if (dispatch_credit) begin
      credit_pulses++;
      disp_credits++;
    end
    check_value(retired_total <= granted_total, 1'b1, "retired entries within granted credits");
  endtask

  task automatic pick_inputs(input bit active, input bit quiet);
    logic [31:0] r;
    int          open_cnt;
    int          pick;
    dispatch_valid = 1'b0;
    wb_valid       = 1'b0;
    flush          = 1'b0;
    retire_credit  = 1'b0;
    r = next_rand();
    if (active && !quiet && (r[5:0] == 6'd0)) begin
      flush = 1'b1; // rare, and never with a dispatch.
    end else if (active && !quiet && (disp_credits > 0) && (r[7:6] != 2'd0)) begin
      dispatch_valid = 1'b1;
    end
    dispatch.dest = rob_pkg::reg_addr_t'(next_rand() % 12); // few registers so renames collide.
    dispatch.src1 = rob_pkg::reg_addr_t'(next_rand() % 12);
    dispatch.src2 = rob_pkg::reg_addr_t'(next_rand() % 12);
    open_cnt = 0;
    foreach (inflight[i]) begin
      if (!inflight[i].done) begin
        open_cnt++;
      end
    end
    r = next_rand();
    wb.tag  = '0;
    wb.data = next_rand();
    if (active && (open_cnt > 0) && (r[1:0] != 2'd0)) begin
      pick = int'((r >> 2) % open_cnt);
      foreach (inflight[i]) begin
        if (!inflight[i].done) begin
          if (pick == 0) begin
            wb.tag = inflight[i].tag;
          end
          pick--;
        end
      end
      wb_valid = 1'b1;
    end
    r = next_rand();
    if ((pending_ret > 0) && (r[1:0] == 2'd0)) begin
      retire_credit = 1'b1;
      pending_ret--;
      granted_total++;
    end
  endtask

  task automatic step_model();
    logic             commit_now;
    rob_pkg::commit_t hd;
    entry_t           e;
    hd         = '0;
    commit_now = 1'b0;
    if (inflight.size() > 0) begin
      hd.tag     = inflight[0].tag;
      hd.dest    = inflight[0].dest;
      hd.data    = inflight[0].data;
      commit_now = inflight[0].done && (ret_credits > 0) && !flush;
    end
    exp_issue_valid = dispatch_valid;
    if (dispatch_valid) begin
      exp_issue.tag  = next_tag;
      exp_issue.dest = dispatch.dest;
      exp_issue.op1  = predict_read(dispatch.src1, commit_now, hd);
      exp_issue.op2  = predict_read(dispatch.src2, commit_now, hd);
    end
    exp_retire_valid = commit_now;
    if (commit_now) begin
      exp_retire = hd;
    end
    ret_credits = ret_credits - int'(commit_now) + int'(retire_credit);
    if (flush) begin
      inflight.delete();
      arch_ref     = '0;
      next_tag     = '0;
      disp_credits = `ROB_DEPTH;
    end else begin
      if (commit_now) begin
        if (hd.dest != '0) begin
          arch_val[hd.dest] = hd.data;
        end
        if (arch_ref[hd.dest] && (arch_tag[hd.dest] == hd.tag)) begin
          arch_ref[hd.dest] = 1'b0; // a younger tag keeps its reference.
        end
        void'(inflight.pop_front());
      end
      if (wb_valid) begin
        foreach (inflight[i]) begin
          if (inflight[i].tag == wb.tag) begin
            inflight[i].done = 1'b1;
            inflight[i].data = wb.data;
          end
        end
      end
      if (dispatch_valid) begin
        if (dispatch.dest != '0) begin
          arch_ref[dispatch.dest] = 1'b1;
          arch_tag[dispatch.dest] = next_tag;
        end
        e = '{tag: next_tag, dest: dispatch.dest, data: '0, done: 1'b0};
        inflight.push_back(e);
        next_tag++;
        disp_credits--;
      end
    end
  endtask

  initial begin
    #(TIMEOUT_NS);
    $display("timeout: run did not finish within %0d ns", TIMEOUT_NS);
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    lcg_state        = 32'd98;
    rst              = 1'b0;
    dispatch_valid   = 1'b0;
    dispatch         = '0;
    wb_valid         = 1'b0;
    wb               = '0;
    flush            = 1'b0;
    retire_credit    = 1'b0;
    errors           = 0;
    retired_total    = 0;
    credit_pulses    = 0;
    pending_ret      = 0;
    granted_total    = `RETIRE_CREDITS;
    ret_credits      = `RETIRE_CREDITS;
    disp_credits     = `ROB_DEPTH;
    next_tag         = '0;
    arch_ref         = '0;
    exp_issue_valid  = 1'b0;
    exp_retire_valid = 1'b0;
    exp_issue        = '0;
    exp_retire       = '0;
    for (int i = 0; i < NUM_REGS; i++) begin
      arch_val[i] = '0;
      arch_tag[i] = '0;
    end
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b1;
    for (int cycle = 0; cycle < NUM_CYCLES; cycle++) begin
      @(negedge clk);
      observe_outputs();
      pick_inputs(cycle >= IDLE_CYCLES, cycle >= NUM_CYCLES - DRAIN_CYCLES);
      step_model();
    end
    @(negedge clk);
    observe_outputs();
    check_value(credit_pulses, retired_total, "dispatch credit pulses against retired entries");
    $display("errors: %0d, retired entries: %0d, credit pulses: %0d",
             errors, retired_total, credit_pulses);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
